// File: Bender.yml
package:
  name: modexp_copro

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/copro_pkg.sv
      - hdl/copro_ram.sv
      - hdl/mod_mult.sv
      - hdl/mod_exp_engine.sv
      - hdl/inst_sequencer.sv
      - hdl/copro_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/copro_tb.sv

// File: hdl/copro_config.svh
// Coprocessor configuration: word and RAM sizes, prime modulus, message credits, RAM latency
`ifndef COPRO_CONFIG_SVH
`define COPRO_CONFIG_SVH

// Data word width
`define COPRO_WORD_BITS 16

// RAM depths in words
`define COPRO_DATA_DEPTH 256
`define COPRO_INST_DEPTH 64

// Prime modulus for the exponentiation engine
`define COPRO_MODULUS 65521

// Message credits granted at reset
`define COPRO_TX_CREDITS 4

// Cycles from address to read data on either RAM port
`define COPRO_RAM_READ_CYCLES 2

`endif

// File: hdl/copro_pkg.sv
// Coprocessor shared types: words, addresses, instruction format and port structs
`include "copro_config.svh"

package copro_pkg;

  typedef logic [`COPRO_WORD_BITS-1:0] word_t;
  typedef logic [$clog2(`COPRO_DATA_DEPTH)-1:0] data_addr_t;
  typedef logic [$clog2(`COPRO_INST_DEPTH)-1:0] inst_addr_t;
  typedef logic [31:0] inst_word_t;

  // Also used as the sequencer state
  typedef enum logic [3:0] {
    NOOP_WAIT = 4'h0,
    MOD_EXP   = 4'h1,
    SEND_MSG  = 4'h2
  } opcode_t;

  // code in the top nibble, then a, b and reserved bits
  typedef struct packed {
    opcode_t    code;
    data_addr_t a;
    data_addr_t b;
    logic [11:0] rsvd;
  } inst_t;

  typedef struct packed {
    logic       we;
    logic       re;
    logic       sel_inst;
    data_addr_t addr;
    inst_word_t wdata;
  } usr_ram_req_t;

  typedef struct packed {
    logic       rvalid;
    inst_word_t rdata;
  } usr_ram_rsp_t;

  typedef struct packed {
    logic  valid;
    word_t base;
    word_t exponent;
  } exp_job_t;

  typedef struct packed {
    logic  valid;
    word_t value;
  } exp_result_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } tx_msg_t;

endpackage

// File: hdl/copro_ram.sv
// Dual-port RAM with a user port and a system port, two-cycle registered read on both
`timescale 1ns/1ns

module copro_ram #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 256
) (
  input  logic                     i_clk,
  // User port
  input  logic                     i_usr_we,
  input  logic                     i_usr_re,
  input  logic [$clog2(DEPTH)-1:0] i_usr_addr,
  input  logic [WIDTH-1:0]         i_usr_wdata,
  output logic [WIDTH-1:0]         o_usr_rdata,
  output logic                     o_usr_rvalid,
  // System port, reads every cycle
  input  logic                     i_sys_we,
  input  logic [$clog2(DEPTH)-1:0] i_sys_addr,
  input  logic [WIDTH-1:0]         i_sys_wdata,
  output logic [WIDTH-1:0]         o_sys_rdata
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] usr_q1, usr_q2;
  logic [WIDTH-1:0] sys_q1, sys_q2;
  logic             usr_re_d1, usr_re_d2;

  always_ff @(posedge i_clk) begin
    if (i_usr_we) mem[i_usr_addr] <= i_usr_wdata;
    if (i_sys_we) mem[i_sys_addr] <= i_sys_wdata;
  end

  // Array read, then output register
  always_ff @(posedge i_clk) begin
    if (i_usr_re) usr_q1 <= mem[i_usr_addr];
    usr_q2    <= usr_q1;
    usr_re_d1 <= i_usr_re;
    usr_re_d2 <= usr_re_d1;
    sys_q1    <= mem[i_sys_addr];
    sys_q2    <= sys_q1;
  end

  assign o_usr_rdata  = usr_q2;
  assign o_usr_rvalid = usr_re_d2;
  assign o_sys_rdata  = sys_q2;

endmodule

// File: hdl/copro_top.sv
// Coprocessor top: instruction and data RAMs, sequencer and exponentiation engine
`timescale 1ns/1ns
`include "copro_config.svh"

module copro_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  copro_pkg::usr_ram_req_t i_usr_req,
  output copro_pkg::usr_ram_rsp_t o_usr_rsp,
  output copro_pkg::tx_msg_t      o_tx,
  input  logic                    i_tx_credit
);

  localparam int W = `COPRO_WORD_BITS;

  logic                   inst_usr_we, inst_usr_re, data_usr_we, data_usr_re;
  copro_pkg::inst_word_t  inst_usr_rdata;
  logic                   inst_usr_rvalid;
  copro_pkg::word_t       data_usr_rdata;
  logic                   data_usr_rvalid;

  copro_pkg::inst_addr_t  inst_sys_addr;
  copro_pkg::inst_word_t  inst_sys_rdata;
  logic                   data_sys_we;
  copro_pkg::data_addr_t  data_sys_addr;
  copro_pkg::word_t       data_sys_wdata, data_sys_rdata;

  copro_pkg::exp_job_t    job;
  copro_pkg::exp_result_t result;

  // Requests held off during reset so the read-valid pipes come out clean
  assign inst_usr_we = i_usr_req.we && i_usr_req.sel_inst && !i_rst;
  assign inst_usr_re = i_usr_req.re && i_usr_req.sel_inst && !i_rst;
  assign data_usr_we = i_usr_req.we && !i_usr_req.sel_inst && !i_rst;
  assign data_usr_re = i_usr_req.re && !i_usr_req.sel_inst && !i_rst;

  always_comb begin
    o_usr_rsp.rvalid = inst_usr_rvalid || data_usr_rvalid;
    o_usr_rsp.rdata  = inst_usr_rvalid ? inst_usr_rdata
                                       : copro_pkg::inst_word_t'(data_usr_rdata);
  end

  copro_ram #(.WIDTH($bits(copro_pkg::inst_word_t)), .DEPTH(`COPRO_INST_DEPTH)) inst_ram_i (
    .i_clk        (i_clk),
    .i_usr_we     (inst_usr_we),
    .i_usr_re     (inst_usr_re),
    .i_usr_addr   (copro_pkg::inst_addr_t'(i_usr_req.addr)),
    .i_usr_wdata  (i_usr_req.wdata),
    .o_usr_rdata  (inst_usr_rdata),
    .o_usr_rvalid (inst_usr_rvalid),
    .i_sys_we     (1'b0),
    .i_sys_addr   (inst_sys_addr),
    .i_sys_wdata  ('0),
    .o_sys_rdata  (inst_sys_rdata)
  );

  copro_ram #(.WIDTH(W), .DEPTH(`COPRO_DATA_DEPTH)) data_ram_i (
    .i_clk        (i_clk),
    .i_usr_we     (data_usr_we),
    .i_usr_re     (data_usr_re),
    .i_usr_addr   (i_usr_req.addr),
    .i_usr_wdata  (i_usr_req.wdata[W-1:0]),
    .o_usr_rdata  (data_usr_rdata),
    .o_usr_rvalid (data_usr_rvalid),
    .i_sys_we     (data_sys_we),
    .i_sys_addr   (data_sys_addr),
    .i_sys_wdata  (data_sys_wdata),
    .o_sys_rdata  (data_sys_rdata)
  );

  inst_sequencer inst_sequencer_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_inst_addr  (inst_sys_addr),
    .i_inst_rdata (inst_sys_rdata),
    .o_data_we    (data_sys_we),
    .o_data_addr  (data_sys_addr),
    .o_data_wdata (data_sys_wdata),
    .i_data_rdata (data_sys_rdata),
    .o_job        (job),
    .i_result     (result),
    .o_tx         (o_tx),
    .i_tx_credit  (i_tx_credit)
  );

  mod_exp_engine mod_exp_engine_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_job    (job),
    .o_result (result)
  );

endmodule

// File: hdl/inst_sequencer.sv
// Instruction sequencer: fetch, decode and step through MOD_EXP and SEND_MSG with credits
`timescale 1ns/1ns
`include "copro_config.svh"

module inst_sequencer (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // Instruction RAM system port
  output copro_pkg::inst_addr_t  o_inst_addr,
  input  copro_pkg::inst_word_t  i_inst_rdata,
  // Data RAM system port
  output logic                   o_data_we,
  output copro_pkg::data_addr_t  o_data_addr,
  output copro_pkg::word_t       o_data_wdata,
  input  copro_pkg::word_t       i_data_rdata,
  // Engine
  output copro_pkg::exp_job_t    o_job,
  input  copro_pkg::exp_result_t i_result,
  // Message port
  output copro_pkg::tx_msg_t     o_tx,
  input  logic                   i_tx_credit
);

  localparam int RD       = `COPRO_RAM_READ_CYCLES;
  localparam int TXC_BITS = $clog2(`COPRO_TX_CREDITS + 1);
  localparam logic [2:0] STEP_FETCH = 3'd7;

  copro_pkg::opcode_t    inst_state;
  logic [2:0]            step;
  copro_pkg::inst_addr_t pc;
  copro_pkg::inst_t      curr_inst;
  logic [RD:0]           inst_read, data_read;

  logic                  data_we_q;
  copro_pkg::data_addr_t data_addr_q;
  copro_pkg::word_t      data_wdata_q;
  copro_pkg::exp_job_t   job_q;
  copro_pkg::tx_msg_t    tx_q;

  logic                  eng_credit;
  logic [TXC_BITS-1:0]   tx_credits;
  logic                  dispatch, job_fire, tx_fire;

  assign curr_inst = copro_pkg::inst_t'(i_inst_rdata);

  // Fetched word for pc is on the RAM output
  assign dispatch = inst_read[RD] && (inst_state == copro_pkg::NOOP_WAIT || step == STEP_FETCH);
  assign job_fire = (inst_state == copro_pkg::MOD_EXP) && (step == 3'd4) && eng_credit;
  assign tx_fire  = (inst_state == copro_pkg::SEND_MSG) && (step == 3'd2) && (tx_credits != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inst_state  <= copro_pkg::NOOP_WAIT;
      step        <= '0;
      pc          <= '0;
      inst_read   <= '0;
      data_read   <= '0;
      data_we_q   <= 1'b0;
      job_q.valid <= 1'b0;
      tx_q.valid  <= 1'b0;
    end else begin
      inst_read   <= inst_read << 1;
      data_read   <= data_read << 1;
      data_we_q   <= 1'b0;
      job_q.valid <= 1'b0;
      tx_q.valid  <= 1'b0;

      if (dispatch) begin
        inst_read <= '0;
        step      <= '0;
        // Unknown or unwritten codes park the sequencer
        if (curr_inst.code == copro_pkg::MOD_EXP || curr_inst.code == copro_pkg::SEND_MSG)
          inst_state <= curr_inst.code;
        else
          inst_state <= copro_pkg::NOOP_WAIT;
      end else begin
        case (inst_state)
          copro_pkg::NOOP_WAIT: inst_read[0] <= 1'b1;
          copro_pkg::MOD_EXP: begin
            case (step)
              3'd0: begin
                data_addr_q  <= curr_inst.a;
                data_read[0] <= 1'b1;
                step         <= 3'd1;
              end
              3'd1: begin
                data_addr_q  <= curr_inst.a + copro_pkg::data_addr_t'(1);
                data_read[0] <= 1'b1;
                step         <= 3'd2;
              end
              3'd2: begin
                if (data_read[RD]) begin
                  job_q.base <= i_data_rdata;
                  step       <= 3'd3;
                end
              end
              3'd3: begin
                if (data_read[RD]) begin
                  job_q.exponent <= i_data_rdata;
                  step           <= 3'd4;
                end
              end
              3'd4: begin
                if (job_fire) begin
                  job_q.valid <= 1'b1;
                  step        <= 3'd5;
                end
              end
              3'd5: begin
                if (i_result.valid) begin
                  data_addr_q  <= curr_inst.b;
                  data_wdata_q <= i_result.value;
                  data_we_q    <= 1'b1;
                  pc           <= pc + copro_pkg::inst_addr_t'(1);
                  inst_read[0] <= 1'b1;
                  step         <= STEP_FETCH;
                end
              end
              default: ;
            endcase
          end
          copro_pkg::SEND_MSG: begin
            case (step)
              3'd0: begin
                data_addr_q  <= curr_inst.a;
                data_read[0] <= 1'b1;
                step         <= 3'd1;
              end
              3'd1: begin
                if (data_read[RD]) begin
                  tx_q.data <= i_data_rdata;
                  step      <= 3'd2;
                end
              end
              // Stalls here without a message credit
              3'd2: begin
                if (tx_fire) begin
                  tx_q.valid   <= 1'b1;
                  pc           <= pc + copro_pkg::inst_addr_t'(1);
                  inst_read[0] <= 1'b1;
                  step         <= STEP_FETCH;
                end
              end
              default: ;
            endcase
          end
          default: inst_state <= copro_pkg::NOOP_WAIT;
        endcase
      end
    end
  end

  // One engine credit, returned by the result pulse
  always_ff @(posedge i_clk) begin
    if (i_rst) eng_credit <= 1'b1;
    else if (job_fire) eng_credit <= 1'b0;
    else if (i_result.valid) eng_credit <= 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tx_credits <= TXC_BITS'(`COPRO_TX_CREDITS);
    end else begin
      case ({i_tx_credit, tx_fire})
        2'b10:   tx_credits <= tx_credits + 1'b1;
        2'b01:   tx_credits <= tx_credits - 1'b1;
        default: tx_credits <= tx_credits;
      endcase
    end
  end

  assign o_inst_addr  = pc;
  assign o_data_we    = data_we_q;
  assign o_data_addr  = data_addr_q;
  assign o_data_wdata = data_wdata_q;
  assign o_job        = job_q;
  assign o_tx         = tx_q;

endmodule

// File: hdl/mod_exp_engine.sv
// Square-and-multiply modular exponentiation engine on a single shared multiplier
`timescale 1ns/1ns
`include "copro_config.svh"

module mod_exp_engine (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  copro_pkg::exp_job_t    i_job,
  output copro_pkg::exp_result_t o_result
);

  localparam int W  = `COPRO_WORD_BITS;
  localparam int CW = $clog2(W);
  localparam logic [W:0] MOD = (W + 1)'(`COPRO_MODULUS);

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_SCAN,
    ENG_SQR,
    ENG_MUL
  } eng_state_t;

  eng_state_t             state;
  copro_pkg::word_t       base_r, exp_r;
  logic [CW-1:0]          cnt;
  logic [W:0]             base_ext;
  copro_pkg::exp_result_t result_q;

  logic             mm_start, mm_done;
  copro_pkg::word_t mm_a, mm_b, mm_prod;

  assign base_ext = {1'b0, i_job.base};

  // cnt holds the exponent bits still to process below the top of exp_r
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state          <= ENG_IDLE;
      mm_start       <= 1'b0;
      result_q.valid <= 1'b0;
    end else begin
      mm_start       <= 1'b0;
      result_q.valid <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (i_job.valid) begin
            base_r <= (base_ext >= MOD) ? W'(base_ext - MOD) : i_job.base;
            exp_r  <= i_job.exponent;
            cnt    <= CW'(W - 1);
            if (i_job.exponent == '0) begin
              result_q.value <= W'(1);
              result_q.valid <= 1'b1;
            end else begin
              state <= ENG_SCAN;
            end
          end
        end
        // Skip leading zeros, the leading one loads the base
        ENG_SCAN: begin
          exp_r <= exp_r << 1;
          if (exp_r[W-1]) begin
            if (cnt == '0) begin
              result_q.value <= base_r;
              result_q.valid <= 1'b1;
              state          <= ENG_IDLE;
            end else begin
              mm_a     <= base_r;
              mm_b     <= base_r;
              mm_start <= 1'b1;
              state    <= ENG_SQR;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ENG_SQR, ENG_MUL: begin
          if (mm_done) begin
            if (state == ENG_SQR && exp_r[W-1]) begin
              mm_a     <= mm_prod;
              mm_b     <= base_r;
              mm_start <= 1'b1;
              state    <= ENG_MUL;
            end else begin
              // Bit finished
              exp_r <= exp_r << 1;
              cnt   <= cnt - 1'b1;
              if (cnt == CW'(1)) begin
                result_q.value <= mm_prod;
                result_q.valid <= 1'b1;
                state          <= ENG_IDLE;
              end else begin
                mm_a     <= mm_prod;
                mm_b     <= mm_prod;
                mm_start <= 1'b1;
                state    <= ENG_SQR;
              end
            end
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  mod_mult mod_mult_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (mm_start),
    .i_a     (mm_a),
    .i_b     (mm_b),
    .o_prod  (mm_prod),
    .o_done  (mm_done)
  );

  assign o_result = result_q;

endmodule

// File: hdl/mod_mult.sv
// Sequential modular multiplier, one bit of b per cycle, MSB first
`timescale 1ns/1ns
`include "copro_config.svh"

module mod_mult (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_start,
  input  copro_pkg::word_t i_a,
  input  copro_pkg::word_t i_b,
  output copro_pkg::word_t o_prod,
  output logic             o_done
);

  localparam int W  = `COPRO_WORD_BITS;
  localparam int CW = $clog2(W + 1);
  localparam logic [W:0] MOD = (W + 1)'(`COPRO_MODULUS);

  copro_pkg::word_t a_q, b_q, acc_q;
  logic [CW-1:0]    bits_left;
  logic             busy;
  logic             done_q;
  logic [W:0]       a_ext;
  logic [W:0]       dbl, dbl_red, sum, sum_red;

  assign a_ext = {1'b0, i_a};

  // Double, reduce, add a on a one bit, reduce again
  always_comb begin
    dbl     = {acc_q, 1'b0};
    dbl_red = (dbl >= MOD) ? dbl - MOD : dbl;
    sum     = dbl_red + (b_q[W-1] ? {1'b0, a_q} : '0);
    sum_red = (sum >= MOD) ? sum - MOD : sum;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy      <= 1'b0;
      done_q    <= 1'b0;
      bits_left <= '0;
    end else begin
      done_q <= 1'b0;
      if (i_start && !busy) begin
        busy      <= 1'b1;
        bits_left <= CW'(W);
      end else if (busy) begin
        bits_left <= bits_left - 1'b1;
        // Last bit lands this edge
        if (bits_left == CW'(1)) begin
          busy   <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start && !busy) begin
      // a must be below the modulus for the single-subtract steps
      a_q   <= (a_ext >= MOD) ? W'(a_ext - MOD) : i_a;
      b_q   <= i_b;
      acc_q <= '0;
    end else if (busy) begin
      acc_q <= sum_red[W-1:0];
      b_q   <= b_q << 1;
    end
  end

  assign o_prod = acc_q;
  assign o_done = done_q;

endmodule

// File: modexp_copro.f
+incdir+hdl
hdl/copro_pkg.sv
hdl/copro_ram.sv
hdl/mod_mult.sv
hdl/mod_exp_engine.sv
hdl/inst_sequencer.sv
hdl/copro_top.sv
testbench/copro_tb.sv

// File: testbench/copro_tb.sv
// Coprocessor testbench: loads programs from the data file, runs them, checks RAM and messages
`timescale 1ns/1ns
`include "copro_config.svh"

module copro_tb;

  localparam int RD = `COPRO_RAM_READ_CYCLES;
  localparam int TXC = `COPRO_TX_CREDITS;
  localparam int W = `COPRO_WORD_BITS;
  // Worst exponent: square and multiply on every bit, W+1 cycles each plus start
  localparam int EXP_CYCLES = 2 * W * (W + 3) + W + 8;
  localparam int MAX_INSTS = 8;
  localparam int TEST_CYCLES = EXP_CYCLES * MAX_INSTS + 2000;
  localparam int QUIET_CYCLES = 64;
  localparam int READ_WAIT = 8;
  localparam int GAP_ENTRIES = 64;
  localparam bit [31:0] SEED = 32'h7876_7950;

  logic                    clk;
  logic                    rst;
  copro_pkg::usr_ram_req_t usr_req;
  copro_pkg::usr_ram_rsp_t usr_rsp;
  copro_pkg::tx_msg_t      tx;
  logic                    tx_credit;

  // Current test record
  string       test_name;
  bit          test_hold;
  logic [31:0] pre_addr[$];
  logic [31:0] pre_val[$];
  logic [31:0] prog_addr[$];
  logic [31:0] prog_val[$];
  logic [31:0] start_word;
  logic [31:0] msg_exp[$];
  logic [31:0] chk_addr[$];
  logic [31:0] chk_val[$];

  // Message receiver and credit return
  logic [W-1:0] rx_q[$];
  int           received;
  int           returned;
  int           gap;
  int           gap_idx;
  int           gap_table[GAP_ENTRIES];
  bit           credit_en;

  int    errors;
  int    tests_run;
  int    tests_failed;
  int    num_tests;
  bit    load_failed;
  int    fd;
  string line;

  copro_top copro_top_i (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_usr_req   (usr_req),
    .o_usr_rsp   (usr_rsp),
    .o_tx        (tx),
    .i_tx_credit (tx_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // o_tx is registered, so take it mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      received = 0;
    end else if (tx.valid) begin
      rx_q.push_back(tx.data);
      received++;
    end
  end

  // One credit back per message, spaced by the random gap table
  always @(posedge clk) begin
    if (rst || !credit_en) begin
      tx_credit <= 1'b0;
      if (rst) returned = 0;
    end else if (gap != 0) begin
      tx_credit <= 1'b0;
      gap--;
    end else if (returned < received) begin
      tx_credit <= 1'b1;
      returned++;
      gap = gap_table[gap_idx];
      gap_idx = (gap_idx + 1) % GAP_ENTRIES;
    end else begin
      tx_credit <= 1'b0;
    end
  end

  initial begin
    wait (num_tests != 0);
    repeat (num_tests * TEST_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", num_tests * TEST_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic compare_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      $display("Failure: %s", what);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic write_word(input logic sel, input logic [7:0] addr, input logic [31:0] wdata);
    copro_pkg::usr_ram_req_t req;
    req = '0;
    req.we = 1'b1;
    req.sel_inst = sel;
    req.addr = addr;
    req.wdata = wdata;
    @(posedge clk);
    usr_req <= req;
    @(posedge clk);
    usr_req <= '0;
  endtask

  // Latency counts cycles after the request cycle until rvalid
  task automatic read_word(input logic sel, input logic [7:0] addr,
                           output logic [31:0] rdata, output int latency);
    copro_pkg::usr_ram_req_t req;
    bit found;
    req = '0;
    req.re = 1'b1;
    req.sel_inst = sel;
    req.addr = addr;
    @(posedge clk);
    usr_req <= req;
    @(posedge clk);
    usr_req <= '0;
    found = 1'b0;
    latency = 0;
    rdata = 'x;
    while (!found && latency < READ_WAIT) begin
      @(negedge clk);
      latency++;
      if (usr_rsp.rvalid) begin
        found = 1'b1;
        rdata = usr_rsp.rdata;
      end
    end
    require(found, $sformatf("no read-valid strobe for address 0x%02h", addr));
  endtask

  task automatic await_messages(input int count);
    int cycles;
    cycles = 0;
    while (rx_q.size() < count && cycles < TEST_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    require(rx_q.size() >= count,
            $sformatf("timed out waiting for %0d messages, got %0d", count, rx_q.size()));
  endtask

  task automatic run_test(input string name, input bit hold);
    int          err_start;
    int          want;
    int          latency;
    logic [31:0] got;
    err_start = errors;
    // Park address 0 so the old program does not restart after reset
    write_word(1'b1, 8'h00, 32'h0);
    apply_reset();
    foreach (pre_addr[i]) write_word(1'b0, pre_addr[i][7:0], {16'h0, pre_val[i][15:0]});
    foreach (prog_addr[i]) write_word(1'b1, prog_addr[i][7:0], prog_val[i]);
    foreach (pre_addr[i]) begin
      read_word(1'b0, pre_addr[i][7:0], got, latency);
      compare_word($sformatf("o_usr_rsp.rdata data[0x%02h]", pre_addr[i][7:0]),
                   got, {16'h0, pre_val[i][15:0]});
      require(latency == RD, $sformatf("data read took %0d cycles", latency));
    end
    foreach (prog_addr[i]) begin
      read_word(1'b1, prog_addr[i][7:0], got, latency);
      compare_word($sformatf("o_usr_rsp.rdata inst[0x%02h]", prog_addr[i][7:0]),
                   got, prog_val[i]);
      require(latency == RD, $sformatf("instruction read took %0d cycles", latency));
    end

    rx_q.delete();
    credit_en <= !hold;
    write_word(1'b1, 8'h00, start_word);
    want = msg_exp.size();
    // Hold credits back until the sequencer has to stall
    if (hold) begin
      await_messages((want < TXC) ? want : TXC);
      repeat (QUIET_CYCLES) @(posedge clk);
      require(rx_q.size() <= TXC, "more messages than initial credits before any return");
      credit_en <= 1'b1;
    end
    await_messages(want);
    repeat (QUIET_CYCLES) @(posedge clk);
    require(rx_q.size() == want,
            $sformatf("%0d messages received, %0d expected", rx_q.size(), want));
    foreach (msg_exp[i]) begin
      if (i < rx_q.size())
        compare_word($sformatf("o_tx.data message %0d", i), {16'h0, rx_q[i]},
                     {16'h0, msg_exp[i][15:0]});
    end
    foreach (chk_addr[i]) begin
      read_word(1'b0, chk_addr[i][7:0], got, latency);
      compare_word($sformatf("o_usr_rsp.rdata data[0x%02h]", chk_addr[i][7:0]),
                   got, {16'h0, chk_val[i][15:0]});
    end

    tests_run++;
    if (errors == err_start) begin
      $display("test %-14s passed", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic process_line(input string text);
    string       tag;
    string       arg;
    logic [31:0] v1;
    logic [31:0] v2;
    int          hold_v;
    int          n;
    n = $sscanf(text, "%s", tag);
    if (n != 1 || tag.substr(0, 0) == "#") return;
    case (tag)
      "N": n = $sscanf(text, "%s %d", tag, num_tests);
      "T": begin
        n = $sscanf(text, "%s %s %d", tag, arg, hold_v);
        test_name = arg;
        test_hold = (hold_v != 0);
        pre_addr.delete();
        pre_val.delete();
        prog_addr.delete();
        prog_val.delete();
        msg_exp.delete();
        chk_addr.delete();
        chk_val.delete();
        start_word = '0;
      end
      "D", "P", "E": begin
        n = $sscanf(text, "%s %h %h", tag, v1, v2);
        require(n == 3, $sformatf("record %s needs an address and a value", tag));
        if (tag == "D") begin
          pre_addr.push_back(v1);
          pre_val.push_back(v2);
        end else if (tag == "P") begin
          prog_addr.push_back(v1);
          prog_val.push_back(v2);
        end else begin
          chk_addr.push_back(v1);
          chk_val.push_back(v2);
        end
      end
      "S": begin
        n = $sscanf(text, "%s %h", tag, v1);
        start_word = v1;
      end
      "M": begin
        n = $sscanf(text, "%s %h", tag, v1);
        msg_exp.push_back(v1);
      end
      "R": run_test(test_name, test_hold);
      default: require(1'b0, $sformatf("unknown record %s in data file", tag));
    endcase
  endtask

  initial begin
    rst = 1'b1;
    usr_req = '0;
    tx_credit = 1'b0;
    credit_en = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    num_tests = 0;
    load_failed = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < GAP_ENTRIES; i++) gap_table[i] = 1 + ($urandom % 7);
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("testbench/copro_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      load_failed = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) process_line(line);
      $fclose(fd);
    end

    $display("tests run %0d of %0d, failed %0d, errors %0d",
             tests_run, num_tests, tests_failed, errors);
    if (errors == 0 && !load_failed && num_tests > 0 && tests_run == num_tests) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/copro_testdata.txt
# Records: N tests | T name hold | D addr data | P addr inst | S inst | M msg | E addr data | R
# Inst: code[31:28] a[27:20] b[19:12], code 0 NOOP_WAIT, 1 MOD_EXP, 2 SEND_MSG; values in hex
N 5
T user_ram 0
D 05 a5c3
D 06 ffff
P 3e 12345678
P 3f deadbeef
S 00000000
E 05 a5c3
E 06 ffff
R
# 3^10 mod 65521
T single_exp 0
D 10 0003
D 11 000a
D 12 ffff
S 11012000
P 01 21200000
P 02 00000000
M e6a9
E 12 e6a9
R
# Exponent 0, exponent 1, base 0, base above the modulus
T edge_exp 0
D 20 0007
D 21 0000
D 22 1234
D 23 0001
D 24 0000
D 25 0005
D 26 ffff
D 27 0002
D 30 ffff
D 31 ffff
D 32 ffff
S 12030000
P 01 12231000
P 02 12432000
P 03 12633000
P 04 23100000
P 05 23300000
P 06 00000000
M 1234
M 00c4
E 30 0001
E 31 1234
E 32 0000
E 33 00c4
R
# Each result feeds the next job
T chain_exp 0
D 40 0002
D 41 0010
D 51 0002
D 61 0002
S 14050000
P 01 15060000
P 02 16070000
P 03 27000000
P 04 00000000
M c5c1
E 50 000f
E 60 00e1
E 70 c5c1
R
# Six messages against four initial credits
T backpressure 1
D 90 1111
D 91 2222
D 92 3333
D 93 4444
D 94 5555
D 95 6666
S 29000000
P 01 29100000
P 02 29200000
P 03 29300000
P 04 29400000
P 05 29500000
P 06 00000000
M 1111
M 2222
M 3333
M 4444
M 5555
M 6666
R
